// File: Makefile
TOP = tb_fadd

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f vlog.f --top-module $(TOP) -o $(TOP)
	out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

// File: fadd.sv
/*
  double-precision add and subtract, two-stage pipeline
*/
`timescale 1ns/10ps
module fadd (
  input  logic               clk,
  input  logic               rst,
  input  logic               en,
  input  fadd_pkg::fp_word_t a,
  input  fadd_pkg::fp_word_t b,
  input  logic               is_sub,
  input  fadd_pkg::rmode_t   rmode,
  output fadd_pkg::fp_word_t res,
  output fadd_pkg::flags_t   raise,
  output logic               res_valid
);
  logic               s1_special;
  fadd_pkg::fp_word_t s1_special_res;
  logic               s1_invalid;
  logic               s1_valid;
  logic               s1_sign;
  logic               s1_eff_sub;
  fadd_pkg::exp_t     s1_exp;
  fadd_pkg::mant_t    s1_mant_big;
  fadd_pkg::mant_t    s1_mant_small;
  fadd_pkg::rmode_t   s1_rmode;

  fadd_special i_special (
    .clk            (clk),
    .rst            (rst),
    .en             (en),
    .a              (a),
    .b              (b),
    .is_sub         (is_sub),
    .rmode          (rmode),
    .s1_special     (s1_special),
    .s1_special_res (s1_special_res),
    .s1_invalid     (s1_invalid)
  );

  fadd_align i_align (
    .clk           (clk),
    .rst           (rst),
    .en            (en),
    .a             (a),
    .b             (b),
    .is_sub        (is_sub),
    .rmode         (rmode),
    .s1_valid      (s1_valid),
    .s1_sign       (s1_sign),
    .s1_eff_sub    (s1_eff_sub),
    .s1_exp        (s1_exp),
    .s1_mant_big   (s1_mant_big),
    .s1_mant_small (s1_mant_small),
    .s1_rmode      (s1_rmode)
  );

  fadd_add_round i_add_round (
    .clk            (clk),
    .rst            (rst),
    .s1_valid       (s1_valid),
    .s1_sign        (s1_sign),
    .s1_eff_sub     (s1_eff_sub),
    .s1_exp         (s1_exp),
    .s1_mant_big    (s1_mant_big),
    .s1_mant_small  (s1_mant_small),
    .s1_rmode       (s1_rmode),
    .s1_special     (s1_special),
    .s1_special_res (s1_special_res),
    .s1_invalid     (s1_invalid),
    .res            (res),
    .raise          (raise),
    .res_valid      (res_valid)
  );

endmodule

// File: fadd_add_round.sv
/*
  stage 2: mantissa add or subtract, renormalize, round by mode,
  range checks, special result select and output registers
*/
`timescale 1ns/10ps
module fadd_add_round (
  input  logic               clk,
  input  logic               rst,
  input  logic               s1_valid,
  input  logic               s1_sign,
  input  logic               s1_eff_sub,
  input  fadd_pkg::exp_t     s1_exp,
  input  fadd_pkg::mant_t    s1_mant_big,
  input  fadd_pkg::mant_t    s1_mant_small,
  input  fadd_pkg::rmode_t   s1_rmode,
  input  logic               s1_special,
  input  fadd_pkg::fp_word_t s1_special_res,
  input  logic               s1_invalid,
  output fadd_pkg::fp_word_t res,
  output fadd_pkg::flags_t   raise,
  output logic               res_valid
);
  logic [fadd_pkg::MANT_W:0]   sum;
  fadd_pkg::mant_t             mant_n;
  fadd_pkg::exp_t              exp_n;
  logic                        sum_zero;
  logic                        sum_tiny;
  logic                        lsb, guard, rest;
  logic                        round_up;
  logic [fadd_pkg::FRAC_W+1:0] rounded;
  logic [fadd_pkg::FRAC_W-1:0] frac_r;
  logic [fadd_pkg::EXP_W:0]    exp_r;
  logic                        to_inf;
  fadd_pkg::fp_word_t          res_d;
  fadd_pkg::flags_t            raise_d;

  // big is never smaller, so the difference stays non-negative
  assign sum = s1_eff_sub ? {1'b0, s1_mant_big} - {1'b0, s1_mant_small}
                          : {1'b0, s1_mant_big} + {1'b0, s1_mant_small};

  fadd_renorm i_renorm (
    .mant_in  (sum),
    .exp_in   (s1_exp),
    .mant_out (mant_n),
    .exp_out  (exp_n),
    .is_zero  (sum_zero),
    .tiny     (sum_tiny)
  );

  assign lsb   = mant_n[fadd_pkg::GRS_W];
  assign guard = mant_n[fadd_pkg::GRS_W-1];
  assign rest  = |mant_n[fadd_pkg::GRS_W-2:0];

  always_comb begin
    case (s1_rmode)
      fadd_pkg::RM_EVEN:  round_up = guard && (rest || lsb);
      fadd_pkg::RM_PLUS:  round_up = !s1_sign && (guard || rest);
      fadd_pkg::RM_MINUS: round_up = s1_sign && (guard || rest);
      default:            round_up = 1'b0;
    endcase
  end

  // a rounding carry gives 1.000 with the exponent one up
  assign rounded = {1'b0, mant_n[fadd_pkg::MANT_W-1:fadd_pkg::GRS_W]} +
                   {{(fadd_pkg::FRAC_W + 1){1'b0}}, round_up};
  assign frac_r  = rounded[fadd_pkg::FRAC_W+1] ? rounded[fadd_pkg::FRAC_W:1]
                                               : rounded[fadd_pkg::FRAC_W-1:0];
  assign exp_r   = {1'b0, exp_n} + {{fadd_pkg::EXP_W{1'b0}}, rounded[fadd_pkg::FRAC_W+1]};

  assign to_inf = s1_rmode == fadd_pkg::RM_EVEN ||
                  (s1_rmode == fadd_pkg::RM_PLUS && !s1_sign) ||
                  (s1_rmode == fadd_pkg::RM_MINUS && s1_sign);

  always_comb begin
    raise_d = '0;
    if (s1_special) begin
      res_d = s1_special_res;
      raise_d[fadd_pkg::FLAG_INV] = s1_invalid;
    end else if (sum_zero) begin
      res_d = {s1_rmode == fadd_pkg::RM_MINUS, 63'b0};
    end else if (sum_tiny) begin
      res_d = {s1_sign, 63'b0};
      raise_d[fadd_pkg::FLAG_UNDER]   = 1'b1;
      raise_d[fadd_pkg::FLAG_INEXACT] = 1'b1;
    end else if (exp_r >= {1'b0, fadd_pkg::EXP_ALL_ONES}) begin
      res_d = to_inf ? {s1_sign, fadd_pkg::EXP_ALL_ONES, {fadd_pkg::FRAC_W{1'b0}}}
                     : {s1_sign, fadd_pkg::MAX_FINITE_MAG};
      raise_d[fadd_pkg::FLAG_OVER]    = 1'b1;
      raise_d[fadd_pkg::FLAG_INEXACT] = 1'b1;
    end else begin
      res_d = {s1_sign, exp_r[fadd_pkg::EXP_W-1:0], frac_r};
      raise_d[fadd_pkg::FLAG_INEXACT] = guard | rest;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
      raise     <= '0;
    end else begin
      res_valid <= s1_valid;
      if (s1_valid) begin
        raise <= raise_d;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      res <= res_d;
    end
  end

  // the arithmetic path can never produce a NaN
  a_nan_from_special: assert property (@(posedge clk) disable iff (rst)
    res_valid && res[62:52] == fadd_pkg::EXP_ALL_ONES && res[51:0] != '0
      |-> $past(s1_special));

endmodule

// File: fadd_align.sv
/*
  stage 1 datapath: exponent compare, operand swap,
  alignment shift with sticky and effective operation
*/
`timescale 1ns/10ps
module fadd_align (
  input  logic               clk,
  input  logic               rst,
  input  logic               en,
  input  fadd_pkg::fp_word_t a,
  input  fadd_pkg::fp_word_t b,
  input  logic               is_sub,
  input  fadd_pkg::rmode_t   rmode,
  output logic               s1_valid,
  output logic               s1_sign,
  output logic               s1_eff_sub,
  output fadd_pkg::exp_t     s1_exp,
  output fadd_pkg::mant_t    s1_mant_big,
  output fadd_pkg::mant_t    s1_mant_small,
  output fadd_pkg::rmode_t   s1_rmode
);
  fadd_pkg::exp_t  a_exp;
  fadd_pkg::exp_t  b_exp;
  fadd_pkg::exp_t  big_exp;
  fadd_pkg::exp_t  small_exp;
  fadd_pkg::exp_t  exp_diff;
  fadd_pkg::mant_t a_mant;
  fadd_pkg::mant_t b_mant;
  fadd_pkg::mant_t big_mant;
  fadd_pkg::mant_t small_mant;
  fadd_pkg::mant_t lost_mask;
  fadd_pkg::mant_t shifted;
  logic b_sign;
  logic a_more;
  logic big_sign;
  logic sticky;

  assign a_exp  = a[fadd_pkg::FRAC_W +: fadd_pkg::EXP_W];
  assign b_exp  = b[fadd_pkg::FRAC_W +: fadd_pkg::EXP_W];
  assign b_sign = b[63] ^ is_sub;

  // hidden bit only for normal operands, zeros go the special path
  assign a_mant = {a_exp != '0, a[fadd_pkg::FRAC_W-1:0], {fadd_pkg::GRS_W{1'b0}}};
  assign b_mant = {b_exp != '0, b[fadd_pkg::FRAC_W-1:0], {fadd_pkg::GRS_W{1'b0}}};

  // exponent and fraction compare as one magnitude
  assign a_more = a[62:0] >= b[62:0];

  assign big_exp    = a_more ? a_exp : b_exp;
  assign small_exp  = a_more ? b_exp : a_exp;
  assign big_mant   = a_more ? a_mant : b_mant;
  assign small_mant = a_more ? b_mant : a_mant;
  assign big_sign   = a_more ? a[63] : b_sign;
  assign exp_diff   = big_exp - small_exp;

  always_comb begin
    lost_mask = '0;
    sticky    = 1'b0;
    if (exp_diff >= fadd_pkg::exp_t'(fadd_pkg::MANT_W)) begin
      // shifted out completely, only sticky survives
      shifted = {{(fadd_pkg::MANT_W - 1){1'b0}}, |small_mant};
    end else begin
      lost_mask  = ~({fadd_pkg::MANT_W{1'b1}} << exp_diff);
      sticky     = |(small_mant & lost_mask);
      shifted    = small_mant >> exp_diff;
      shifted[0] = shifted[0] | sticky;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= en;
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      s1_sign       <= big_sign;
      s1_eff_sub    <= a[63] ^ b_sign;
      s1_exp        <= big_exp;
      s1_mant_big   <= big_mant;
      s1_mant_small <= shifted;
      s1_rmode      <= rmode;
    end
  end

  a_big_normalized: assert property (@(posedge clk) disable iff (rst)
    s1_valid && s1_exp != '0 |-> s1_mant_big[fadd_pkg::MANT_W-1]);

endmodule

// File: fadd_pkg.sv
/*
  double format sizes, rounding-mode codes and flag indices
  constant result words and word types of the adder
*/
package fadd_pkg;

  // double format
  localparam int EXP_W  = 11;
  localparam int FRAC_W = 52;
  localparam int BIAS   = 1023;

  // guard, round and sticky kept below the fraction
  localparam int GRS_W  = 3;
  localparam int MANT_W = 1 + FRAC_W + GRS_W;

  typedef logic [EXP_W+FRAC_W:0] fp_word_t;
  typedef logic [MANT_W-1:0]     mant_t;
  typedef logic [EXP_W-1:0]      exp_t;
  typedef logic [1:0]            rmode_t;
  typedef logic [3:0]            flags_t;

  localparam exp_t EXP_ALL_ONES = '1;

  // rounding modes
  localparam rmode_t RM_TRUNC = 2'd0;
  localparam rmode_t RM_EVEN  = 2'd1;
  localparam rmode_t RM_PLUS  = 2'd2;
  localparam rmode_t RM_MINUS = 2'd3;

  // bit positions in raise
  localparam int FLAG_INV     = 0;
  localparam int FLAG_OVER    = 1;
  localparam int FLAG_UNDER   = 2;
  localparam int FLAG_INEXACT = 3;

  localparam fp_word_t QNAN = {1'b0, EXP_ALL_ONES, 1'b1, {(FRAC_W - 1){1'b0}}};

  // sign is prepended where used
  localparam logic [EXP_W+FRAC_W-1:0] MAX_FINITE_MAG =
    {EXP_ALL_ONES - exp_t'(1), {FRAC_W{1'b1}}};

endpackage

// File: fadd_renorm.sv
/*
  renormalization after add or subtract: leading-one search,
  shift with exponent adjust, zero and tiny detection
*/
`timescale 1ns/10ps
module fadd_renorm (
  input  logic [fadd_pkg::MANT_W:0] mant_in,
  input  fadd_pkg::exp_t            exp_in,
  output fadd_pkg::mant_t           mant_out,
  output fadd_pkg::exp_t            exp_out,
  output logic                      is_zero,
  output logic                      tiny
);
  localparam int CNT_W = $clog2(fadd_pkg::MANT_W + 1);

  logic [CNT_W-1:0] lzc;
  fadd_pkg::exp_t   lzc_ext;

  // leading zeros below the carry bit, scanned from the bottom up
  always_comb begin
    lzc = CNT_W'(fadd_pkg::MANT_W);
    for (int i = 0; i < fadd_pkg::MANT_W; i++) begin
      if (mant_in[i]) begin
        lzc = CNT_W'(fadd_pkg::MANT_W - 1 - i);
      end
    end
  end

  assign lzc_ext = fadd_pkg::exp_t'(lzc);
  assign is_zero = mant_in == '0;

  always_comb begin
    if (mant_in[fadd_pkg::MANT_W]) begin
      // carry out, dropped bit folds into sticky
      mant_out = {mant_in[fadd_pkg::MANT_W:2], |mant_in[1:0]};
      exp_out  = exp_in + fadd_pkg::exp_t'(1);
      tiny     = 1'b0;
    end else begin
      mant_out = mant_in[fadd_pkg::MANT_W-1:0] << lzc;
      exp_out  = exp_in - lzc_ext;
      // exponent would fall below one
      tiny     = lzc_ext >= exp_in;
    end
  end

endmodule

// File: fadd_special.sv
/*
  operand classification and special-case result select,
  registered into stage 1 together with the invalid flag
*/
`timescale 1ns/10ps
module fadd_special (
  input  logic               clk,
  input  logic               rst,
  input  logic               en,
  input  fadd_pkg::fp_word_t a,
  input  fadd_pkg::fp_word_t b,
  input  logic               is_sub,
  input  fadd_pkg::rmode_t   rmode,
  output logic               s1_special,
  output fadd_pkg::fp_word_t s1_special_res,
  output logic               s1_invalid
);
  fadd_pkg::exp_t a_exp;
  fadd_pkg::exp_t b_exp;
  logic a_sign, b_sign;
  logic a_zero, a_inf, a_nan, a_snan;
  logic b_zero, b_inf, b_nan, b_snan;
  logic special;
  logic invalid;
  fadd_pkg::fp_word_t special_res;

  assign a_exp  = a[fadd_pkg::FRAC_W +: fadd_pkg::EXP_W];
  assign b_exp  = b[fadd_pkg::FRAC_W +: fadd_pkg::EXP_W];
  assign a_sign = a[63];
  assign b_sign = b[63] ^ is_sub;

  // subnormals count as zero
  assign a_zero = a_exp == '0;
  assign b_zero = b_exp == '0;
  assign a_inf  = a_exp == fadd_pkg::EXP_ALL_ONES && a[fadd_pkg::FRAC_W-1:0] == '0;
  assign b_inf  = b_exp == fadd_pkg::EXP_ALL_ONES && b[fadd_pkg::FRAC_W-1:0] == '0;
  assign a_nan  = a_exp == fadd_pkg::EXP_ALL_ONES && a[fadd_pkg::FRAC_W-1:0] != '0;
  assign b_nan  = b_exp == fadd_pkg::EXP_ALL_ONES && b[fadd_pkg::FRAC_W-1:0] != '0;
  assign a_snan = a_nan && !a[fadd_pkg::FRAC_W-1];
  assign b_snan = b_nan && !b[fadd_pkg::FRAC_W-1];

  assign special = a_nan | b_nan | a_inf | b_inf | a_zero | b_zero;

  always_comb begin
    invalid = 1'b0;
    if (a_nan || b_nan) begin
      special_res = fadd_pkg::QNAN;
      invalid     = a_snan | b_snan;
    end else if (a_inf && b_inf && a_sign != b_sign) begin
      special_res = fadd_pkg::QNAN;
      invalid     = 1'b1;
    end else if (a_inf) begin
      special_res = a;
    end else if (b_inf) begin
      special_res = {b_sign, b[62:0]};
    end else if (a_zero && b_zero) begin
      // unlike signs give +0 except when rounding down
      special_res = {(a_sign == b_sign) ? a_sign : rmode == fadd_pkg::RM_MINUS, 63'b0};
    end else if (a_zero) begin
      special_res = {b_sign, b[62:0]};
    end else begin
      special_res = a;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_special <= 1'b0;
      s1_invalid <= 1'b0;
    end else if (en) begin
      s1_special <= special;
      s1_invalid <= invalid;
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      s1_special_res <= special_res;
    end
  end

  a_inv_is_special: assert property (@(posedge clk) disable iff (rst)
    s1_invalid |-> s1_special);

endmodule

// File: fadd_model.svh
/*
  reference model of the adder as functions: operand builder,
  NaN test and an exact wide add with a single rounding step
*/
`ifndef FADD_MODEL_SVH
`define FADD_MODEL_SVH

// sign, unbiased exponent and fraction to a double word
function automatic fadd_pkg::fp_word_t fp_make(bit s, int e, bit [51:0] f);
  return {s, 11'(e + fadd_pkg::BIAS), f};
endfunction

function automatic bit fp_is_nan(fadd_pkg::fp_word_t w);
  return w[62:52] == fadd_pkg::EXP_ALL_ONES && w[51:0] != '0;
endfunction

function automatic void fadd_model(input fadd_pkg::fp_word_t a, input fadd_pkg::fp_word_t b,
                                   input bit is_sub, input fadd_pkg::rmode_t rm,
                                   output fadd_pkg::fp_word_t r,
                                   output fadd_pkg::flags_t fl);
  fadd_pkg::fp_word_t x;
  fadd_pkg::fp_word_t y;
  bit [119:0] m;
  bit [53:0] q;
  bit g, st, up, s;
  int d, p, e;
  fl = '0;
  y = {b[63] ^ is_sub, b[62:0]};
  if (fp_is_nan(a) || fp_is_nan(y)) begin
    r = fadd_pkg::QNAN;
    fl[fadd_pkg::FLAG_INV] = (fp_is_nan(a) && !a[51]) || (fp_is_nan(y) && !y[51]);
    return;
  end
  // no NaN left, so an all-ones exponent is an infinity
  if (a[62:52] == '1 || y[62:52] == '1) begin
    if (a[62:52] == y[62:52] && a[63] != y[63]) begin
      r = fadd_pkg::QNAN;
      fl[fadd_pkg::FLAG_INV] = 1'b1;
    end else begin
      r = (a[62:52] == '1) ? a : y;
    end
    return;
  end
  if (a[62:52] == '0 && y[62:52] == '0) begin
    r = {(a[63] == y[63]) ? a[63] : rm == fadd_pkg::RM_MINUS, 63'b0};
    return;
  end
  if (a[62:52] == '0 || y[62:52] == '0) begin
    r = (a[62:52] == '0) ? y : a;
    return;
  end
  if (a[62:0] >= y[62:0]) begin
    x = a;
  end else begin
    x = y;
    y = a;
  end
  s = x[63];
  d = int'(x[62:52]) - int'(y[62:52]);
  // exact below 64 bits of difference, sticky only beyond
  m = (d > 64) ? 120'd1 : (120'({1'b1, y[51:0]}) << (64 - d));
  if (x[63] == y[63]) begin
    m = (120'({1'b1, x[51:0]}) << 64) + m;
  end else begin
    m = (120'({1'b1, x[51:0]}) << 64) - m;
  end
  if (m == '0) begin
    r = {rm == fadd_pkg::RM_MINUS, 63'b0};
    return;
  end
  p = 0;
  for (int i = 0; i < 120; i++) begin
    if (m[i]) begin
      p = i;
    end
  end
  e = int'(x[62:52]) + p - 116;
  if (e < 1) begin
    r = {s, 63'b0};
    fl[fadd_pkg::FLAG_UNDER]   = 1'b1;
    fl[fadd_pkg::FLAG_INEXACT] = 1'b1;
    return;
  end
  m  = m << (119 - p);
  g  = m[66];
  st = |m[65:0];
  case (rm)
    fadd_pkg::RM_EVEN:  up = g && (st || m[67]);
    fadd_pkg::RM_PLUS:  up = !s && (g || st);
    fadd_pkg::RM_MINUS: up = s && (g || st);
    default:            up = 1'b0;
  endcase
  q = {1'b0, m[119:67]} + 54'(up);
  if (q[53]) begin
    q = q >> 1;
    e++;
  end
  fl[fadd_pkg::FLAG_INEXACT] = g | st;
  if (e >= 2047) begin
    up = rm == fadd_pkg::RM_EVEN || (rm == fadd_pkg::RM_PLUS && !s) ||
         (rm == fadd_pkg::RM_MINUS && s);
    r = up ? {s, fadd_pkg::EXP_ALL_ONES, 52'b0} : {s, fadd_pkg::MAX_FINITE_MAG};
    fl[fadd_pkg::FLAG_OVER]    = 1'b1;
    fl[fadd_pkg::FLAG_INEXACT] = 1'b1;
  end else begin
    r = {s, 11'(e), q[51:0]};
  end
endfunction

`endif

// File: tb_fadd.sv
/*
  testbench for the two-stage double adder: random operand mix,
  queue of model results, latency and result checks
*/
`timescale 1ns/10ps
module tb_fadd;
  localparam int N_OPS     = 4000;
  localparam int MAX_CYCLE = 3 * N_OPS + 100;

  logic               clk;
  logic               rst;
  logic               en;
  fadd_pkg::fp_word_t a;
  fadd_pkg::fp_word_t b;
  logic               is_sub;
  fadd_pkg::rmode_t   rmode;
  fadd_pkg::fp_word_t res;
  fadd_pkg::flags_t   raise;
  logic               res_valid;

  integer seed = 86;
  int launched = 0;
  int checked = 0;
  int cycles = 0;
  int mismatches = 0;
  int protocol_errors = 0;
  logic [1:0] en_pipe = '0;

  fadd_pkg::fp_word_t res_q[$];
  fadd_pkg::flags_t   raise_q[$];
  bit                 real_ok_q[$];
  logic [63:0]        real_q[$];

  `include "fadd_model.svh"

  fadd i_fadd (
    .clk       (clk),
    .rst       (rst),
    .en        (en),
    .a         (a),
    .b         (b),
    .is_sub    (is_sub),
    .rmode     (rmode),
    .res       (res),
    .raise     (raise),
    .res_valid (res_valid)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLE) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLE);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  function automatic int rand_below(int n);
    return ($random(seed) & 32'h7fff_ffff) % n;
  endfunction

  function automatic logic [51:0] rand_frac();
    logic [63:0] w;
    w = {$random(seed), $random(seed)};
    return w[51:0];
  endfunction

  // normal operand from a biased exponent field
  function automatic fadd_pkg::fp_word_t normal_with_field(int field);
    return fp_make(1'(rand_below(2)), field - fadd_pkg::BIAS, rand_frac());
  endfunction

  function automatic fadd_pkg::fp_word_t pick_special();
    logic [51:0] f;
    f = rand_frac();
    case (rand_below(8))
      0: return {rand_below(2) == 1, 11'h7ff, 1'b1, f[50:0]};
      1: return {rand_below(2) == 1, 11'h7ff, 1'b0, f[50:1], 1'b1};
      2: return {1'b0, 11'h7ff, 52'b0};
      3: return {1'b1, 11'h7ff, 52'b0};
      4: return '0;
      5: return {1'b1, 63'b0};
      // subnormal, read as zero
      6: return {rand_below(2) == 1, 11'h000, f[51:1], 1'b1};
      default: return normal_with_field(1 + rand_below(2046));
    endcase
  endfunction

  task automatic make_operands();
    int field;
    is_sub = 1'(rand_below(2));
    rmode  = fadd_pkg::rmode_t'(rand_below(4));
    case (rand_below(8))
      0, 1: begin
        rmode = fadd_pkg::RM_EVEN;
        a = normal_with_field(1 + rand_below(2046));
        b = normal_with_field(1 + rand_below(2046));
      end
      2, 3: begin
        // exponent difference 0 to 60
        field = 100 + rand_below(1800);
        a = normal_with_field(field);
        b = normal_with_field(field - rand_below(61));
        if (rand_below(2) == 1) begin
          {a, b} = {b, a};
        end
      end
      4: begin
        // equal or near-equal magnitudes, opposite effective sign
        a = normal_with_field(2 + rand_below(2044));
        b = a;
        b[63] = !a[63] ^ is_sub;
        if (rand_below(2) == 1) begin
          b[3:0] = b[3:0] ^ 4'(rand_below(16));
        end
        if (rand_below(4) == 0) begin
          b[62:52] = b[62:52] - 11'd1;
        end
      end
      5: begin
        a = pick_special();
        b = pick_special();
      end
      6: begin
        if (rand_below(2) == 1) begin
          a = normal_with_field(2045 + rand_below(2));
          b = normal_with_field(2040 + rand_below(7));
          b[63] = a[63] ^ is_sub;
        end else begin
          // cancellation down near exponent one
          a = normal_with_field(1 + rand_below(3));
          b = a;
          b[63] = !a[63] ^ is_sub;
          b[7:0] = b[7:0] ^ 8'(rand_below(256));
        end
      end
      default: begin
        a = {$random(seed), $random(seed)};
        b = {$random(seed), $random(seed)};
      end
    endcase
  endtask

  function automatic bit is_finite_normal(fadd_pkg::fp_word_t w);
    return w[62:52] != 11'h000 && w[62:52] != 11'h7ff;
  endfunction

  task automatic launch_op();
    fadd_pkg::fp_word_t want_res;
    fadd_pkg::flags_t   want_raise;
    real                sum;
    make_operands();
    en = 1'b1;
    fadd_model(a, b, is_sub, rmode, want_res, want_raise);
    sum = is_sub ? $bitstoreal(a) - $bitstoreal(b) : $bitstoreal(a) + $bitstoreal(b);
    res_q.push_back(want_res);
    raise_q.push_back(want_raise);
    real_ok_q.push_back(rmode == fadd_pkg::RM_EVEN && is_finite_normal(a) &&
                        is_finite_normal(b) && want_raise == '0);
    real_q.push_back($realtobits(sum));
    launched++;
  endtask

  task automatic check_outputs();
    fadd_pkg::fp_word_t want_res;
    fadd_pkg::flags_t   want_raise;
    bit                 want_real_ok;
    logic [63:0]        want_real;
    assert (res_valid === en_pipe[1]) else begin
      $display("res_valid is %b at %0t but en two cycles earlier was %b",
               res_valid, $time, en_pipe[1]);
      protocol_errors++;
    end
    if (res_valid === 1'b1) begin
      assert (res_q.size() > 0) else begin
        $display("res_valid at %0t with no operation outstanding", $time);
        protocol_errors++;
      end
      if (res_q.size() > 0) begin
        want_res     = res_q.pop_front();
        want_raise   = raise_q.pop_front();
        want_real_ok = real_ok_q.pop_front();
        want_real    = real_q.pop_front();
        checked++;
        assert (res === want_res) else begin
          $display("mismatch at %0t: res %h expected %h", $time, res, want_res);
          mismatches++;
        end
        assert (raise === want_raise) else begin
          $display("mismatch at %0t: raise %b expected %b", $time, raise, want_raise);
          mismatches++;
        end
        if (want_real_ok) begin
          assert (res === want_real) else begin
            $display("mismatch at %0t: res %h real sum %h", $time, res, want_real);
            mismatches++;
          end
        end
      end
    end
  endtask

  // one falling edge: check outputs first, then drive
  task automatic run_cycle(bit allow_launch);
    @(negedge clk);
    check_outputs();
    if (allow_launch && rand_below(4) != 0) begin
      launch_op();
    end else begin
      en = 1'b0;
    end
    en_pipe = {en_pipe[0], en};
  endtask

  initial begin
    rst    = 1'b1;
    en     = 1'b0;
    a      = '0;
    b      = '0;
    is_sub = 1'b0;
    rmode  = fadd_pkg::RM_TRUNC;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    while (launched < N_OPS || res_q.size() > 0) begin
      run_cycle(launched < N_OPS);
    end
    repeat (3) run_cycle(1'b0);
    $display("checked %0d results: %0d mismatches, %0d protocol errors",
             checked, mismatches, protocol_errors);
    if (mismatches == 0 && protocol_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+.
fadd_pkg.sv
fadd_special.sv
fadd_align.sv
fadd_renorm.sv
fadd_add_round.sv
fadd.sv
tb_fadd.sv
